// File: flist.f
logic/bus_pkg.sv
logic/mem_cfg_pkg.sv
logic/mem_arbiter_fsm.sv
logic/wait_state_timer.sv
logic/sram_bank.sv
logic/mem_response_router.sv
logic/mem_subsystem.sv
verif/mem_subsystem_tb.sv

// File: logic/bus_pkg.sv
// Generic bus package: request and response structs and requester identifiers
package bus_pkg;

  localparam int ADDR_W = 32;            // Byte address
  localparam int DATA_W = 32;            // One bus word
  localparam int BE_W   = DATA_W / 8;    // One enable per byte lane

  // Requester side of the bus
  // All fields held as levels until busy drops
  typedef struct packed {
    logic [ADDR_W-1:0] addr;             // Byte address, word aligned
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   byte_en;          // Lane 0 is addr byte 0
    logic              ren;              // Read strobe
    logic              wen;              // Write strobe, never with ren
  } gen_bus_req_t;

  // Responder side
  // busy low for one cycle marks completion
  typedef struct packed {
    logic [DATA_W-1:0] rdata;            // Valid while busy low on a read
    logic              busy;
  } gen_bus_rsp_t;

  // Owner of the memory controller
  typedef enum logic [1:0] {
    REQ_NONE  = 2'd0,                    // Controller idle
    REQ_DATA  = 2'd1,                    // Load/store port
    REQ_INSTR = 2'd2                     // Fetch port, read only
  } requester_t;

endpackage

// File: logic/mem_arbiter_fsm.sv
// Memory controller FSM: grants data or fetch port and sequences one SRAM access
`timescale 1ns/1ps

module mem_arbiter_fsm (
  input  logic                  CLK,
  input  logic                  rst,
  input  bus_pkg::gen_bus_req_t instr_req,
  input  bus_pkg::gen_bus_req_t data_req,
  input  logic                  expired,       // Wait states elapsed
  output bus_pkg::requester_t   grant,
  output logic                  timer_start,
  output logic                  mem_en,
  output logic                  mem_we,
  output logic                  done
);
  import bus_pkg::*;
  import mem_cfg_pkg::*;

  mc_state_t state;
  logic      data_strobe;
  logic      instr_strobe;

  assign data_strobe  = data_req.ren | data_req.wen;
  assign instr_strobe = instr_req.ren;           // Fetch port never writes

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= MC_IDLE;
      grant <= REQ_NONE;
    end else begin
      case (state)
        MC_IDLE: begin
          if (data_strobe) begin                 // Data port wins ties
            grant <= REQ_DATA;
            state <= MC_WAIT;
          end else if (instr_strobe) begin
            grant <= REQ_INSTR;
            state <= MC_WAIT;
          end
        end
        MC_WAIT: begin
          if (expired) state <= MC_ACCESS;
        end
        MC_ACCESS: state <= MC_DONE;
        MC_DONE: begin
          state <= MC_IDLE;                      // Always one idle cycle after
          grant <= REQ_NONE;
        end
        default: state <= MC_IDLE;
      endcase
    end
  end

  // Start timer in the cycle the grant is taken
  assign timer_start = (state == MC_IDLE) && (data_strobe || instr_strobe);
  assign mem_en      = (state == MC_ACCESS);
  assign mem_we      = mem_en && (grant == REQ_DATA) && data_req.wen;  // Stores only
  assign done        = (state == MC_DONE);

  // Array touched WAIT_STATES plus one cycles after the grant is taken
  a_en_after_wait : assert property (@(posedge CLK) disable iff (rst)
    mem_en |-> $past(timer_start, WAIT_STATES + 1));

  // Granted port keeps its strobe until the access completes
  a_grant_held : assert property (@(posedge CLK) disable iff (rst)
    (state != MC_IDLE) |-> (grant == REQ_DATA && data_strobe) ||
                           (grant == REQ_INSTR && instr_strobe));

endmodule

// File: logic/mem_cfg_pkg.sv
// Memory configuration package: SRAM geometry, wait states, controller states, word views
package mem_cfg_pkg;

  localparam int MEM_WORDS   = 256;    // SRAM depth
  localparam int MEM_ADDR_W  = 8;      // Word index, addr[9:2]
  localparam int WAIT_STATES = 3;      // Cycles before the array is touched
  localparam int TIMER_W     = 3;      // Wide enough for WAIT_STATES

  // Controller sequence per access
  typedef enum logic [1:0] {
    MC_IDLE   = 2'd0,    // Pick a requester
    MC_WAIT   = 2'd1,    // Wait states
    MC_ACCESS = 2'd2,    // Array read or RMW
    MC_DONE   = 2'd3     // Busy low on granted port
  } mc_state_t;

  // One SRAM word
  // Full word for reads, byte lanes for masked writes
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lanes;   // lanes[0] is bits 7:0
  } mem_word_u;

endpackage

// File: logic/mem_response_router.sv
// Response router: returns the finished access to its own port and holds rdata between accesses
`timescale 1ns/1ps

module mem_response_router (
  input  logic                   CLK,
  input  logic                   rst,
  input  bus_pkg::requester_t    grant,
  input  logic                   done,       // MC_DONE cycle
  input  mem_cfg_pkg::mem_word_u rd_word,
  output bus_pkg::gen_bus_rsp_t  instr_rsp,
  output bus_pkg::gen_bus_rsp_t  data_rsp
);
  import bus_pkg::*;

  logic              data_hit;
  logic              instr_hit;
  logic [DATA_W-1:0] data_hold;    // Last word returned to data port
  logic [DATA_W-1:0] instr_hold;   // Last word returned to fetch port

  assign data_hit  = done && (grant == REQ_DATA);
  assign instr_hit = done && (grant == REQ_INSTR);

  always_ff @(posedge CLK) begin
    if (rst) begin
      data_hold  <= '0;
      instr_hold <= '0;
    end else begin
      if (data_hit)  data_hold  <= rd_word.word;
      if (instr_hit) instr_hold <= rd_word.word;
    end
  end

  // Fresh word only in the completion cycle
  always_comb begin
    data_rsp.busy   = !data_hit;
    data_rsp.rdata  = data_hit ? rd_word.word : data_hold;
    instr_rsp.busy  = !instr_hit;
    instr_rsp.rdata = instr_hit ? rd_word.word : instr_hold;
  end

  // Completion is a one-cycle pulse, idle cycle follows on both ports
  a_done_pulse : assert property (@(posedge CLK) disable iff (rst)
    (!data_rsp.busy || !instr_rsp.busy) |=> (data_rsp.busy && instr_rsp.busy));

endmodule

// File: logic/mem_subsystem.sv
// Memory subsystem top: data and fetch ports onto one arbitrated wait-stated SRAM
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                  CLK,
  input  logic                  rst,
  input  bus_pkg::gen_bus_req_t instr_req,
  input  bus_pkg::gen_bus_req_t data_req,
  output bus_pkg::gen_bus_rsp_t instr_rsp,
  output bus_pkg::gen_bus_rsp_t data_rsp
);
  import bus_pkg::*;
  import mem_cfg_pkg::*;

  requester_t   grant;
  logic         timer_start;
  logic         expired;
  logic         mem_en;
  logic         mem_we;
  logic         done;
  gen_bus_req_t sel_req;     // Request of the grant holder
  mem_word_u    rd_word;

  mem_arbiter_fsm u_mem_arbiter_fsm (
    .CLK(CLK), .rst(rst),
    .instr_req(instr_req), .data_req(data_req), .expired(expired),
    .grant(grant), .timer_start(timer_start),
    .mem_en(mem_en), .mem_we(mem_we), .done(done)
  );

  wait_state_timer u_wait_state_timer (
    .CLK(CLK), .rst(rst), .start(timer_start), .expired(expired)
  );

  // Fetch only when granted, data otherwise
  assign sel_req = (grant == REQ_INSTR) ? instr_req : data_req;

  sram_bank u_sram_bank (
    .CLK(CLK), .mem_en(mem_en), .mem_we(mem_we), .sel_req(sel_req), .rd_word(rd_word)
  );

  mem_response_router u_mem_response_router (
    .CLK(CLK), .rst(rst), .grant(grant), .done(done), .rd_word(rd_word),
    .instr_rsp(instr_rsp), .data_rsp(data_rsp)
  );

endmodule

// File: logic/sram_bank.sv
// SRAM bank: word-addressed storage with byte-enabled RMW and registered read data
`timescale 1ns/1ps

module sram_bank (
  input  logic                   CLK,
  input  logic                   mem_en,    // One-cycle access strobe
  input  logic                   mem_we,    // Write qualifier for mem_en
  input  bus_pkg::gen_bus_req_t  sel_req,   // Granted request
  output mem_cfg_pkg::mem_word_u rd_word
);
  import mem_cfg_pkg::*;

  mem_word_u             mem [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] idx;
  mem_word_u             cur_word;    // Stored value at idx
  mem_word_u             wr_word;     // Write data, lane view
  mem_word_u             merged;      // Stored word with enabled lanes replaced

  // Array starts cleared, not touched by reset
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign idx      = sel_req.addr[MEM_ADDR_W+1:2];   // Drop byte offset
  assign cur_word = mem[idx];
  assign wr_word  = sel_req.wdata;

  // Lane-by-lane merge
  always_comb begin
    merged = cur_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (sel_req.byte_en[lane]) begin
        merged.lanes[lane] = wr_word.lanes[lane];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[idx] <= merged;
        rd_word  <= merged;       // Write returns the committed word
      end else begin
        rd_word  <= cur_word;
      end
    end
  end

endmodule

// File: logic/wait_state_timer.sv
// Wait-state timer: down-counter that flags the end of the SRAM wait states
`timescale 1ns/1ps

module wait_state_timer (
  input  logic CLK,
  input  logic rst,
  input  logic start,       // One-cycle pulse from the FSM
  output logic expired      // Level, held until next start
);
  import mem_cfg_pkg::*;

  logic [TIMER_W-1:0] count;

  always_ff @(posedge CLK) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      // Start cycle counts as the first wait state
      count <= TIMER_W'(WAIT_STATES - 1);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Rises WAIT_STATES cycles after start
  assign expired = (count == '0) && !start;

  // Expiry lands exactly WAIT_STATES cycles after a start
  a_expiry_time : assert property (@(posedge CLK) disable iff (rst)
    $rose(expired) |-> $past(start, WAIT_STATES));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f flist.f --top-module mem_subsystem_tb \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0

// File: verif/mem_golden_vectors.txt
# name port(D/I/B) op(R/W) addr wdata byte_en expected_rdata order(B lines)
# Write lines hold the word after the lane merge, B lines fetch the same address
rd_unwritten   D R 00000100 00000000 0 00000000 -
fetch_unwritten I R 00000204 00000000 0 00000000 -
wr_full_a      D W 00000010 deadbeef f deadbeef -
rd_full_a      D R 00000010 00000000 0 deadbeef -
wr_full_b      D W 00000014 12345678 f 12345678 -
rd_full_b      D R 00000014 00000000 0 12345678 -
wr_lane0       D W 00000010 000000aa 1 deadbeaa -
rd_lane0       D R 00000010 00000000 0 deadbeaa -
wr_lane23      D W 00000010 5566ffff c 5566beaa -
rd_lane23      D R 00000010 00000000 0 5566beaa -
wr_lane1       D W 00000014 0000c300 2 1234c378 -
fetch_a        I R 00000010 00000000 0 5566beaa -
fetch_b        I R 00000014 00000000 0 1234c378 -
wr_no_lanes    D W 00000018 ffffffff 0 00000000 -
fetch_c        I R 00000018 00000000 0 00000000 -
wr_top         D W 000003fc cafef00d f cafef00d -
fetch_top      I R 000003fc 00000000 0 cafef00d -
both_rd        B R 00000014 00000000 0 1234c378 D
both_wr        B W 00000020 0badc0de f 0badc0de D
both_wr_part   B W 00000014 99000000 8 9934c378 D
rd_after_both  D R 00000020 00000000 0 0badc0de -
wr_lane02      D W 00000020 11223344 5 0b22c044 -
fetch_lane02   I R 00000020 00000000 0 0b22c044 -

// File: verif/mem_subsystem_tb.sv
// Memory subsystem testbench: replays golden vectors on the data and fetch ports
`timescale 1ns/1ps

module mem_subsystem_tb;
  import bus_pkg::*;

  localparam int CLK_HALF  = 10;    // 20 ns period
  localparam int DRIVE_DLY = 2;     // Inputs change after the edge
  localparam int TIMEOUT   = 50;    // Cycles per wait loop
  localparam int LATENCY   = 5;     // 3 wait states, access, done
  localparam int ORDER_GAP = 6;     // Latency plus the idle cycle

  logic         CLK;
  logic         rst;
  gen_bus_req_t instr_req;
  gen_bus_req_t data_req;
  gen_bus_rsp_t instr_rsp;
  gen_bus_rsp_t data_rsp;

  int          pass_count;
  int          fail_count;
  logic        test_ok;                      // Cleared by any failed check
  logic        timed_out;
  logic [31:0] rng;
  logic [31:0] shadow [logic [31:0]];        // Golden word per written address

  mem_subsystem u_mem_subsystem (
    .CLK(CLK), .rst(rst),
    .instr_req(instr_req), .data_req(data_req),
    .instr_rsp(instr_rsp), .data_rsp(data_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift_step(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Enabled lanes take write data, others keep the old word
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) w[8*i +: 8] = wdata[8*i +: 8];
    end
    return w;
  endfunction

  function automatic requester_t order_to_req(input string s);
    return (s == "I") ? REQ_INSTR : REQ_DATA;
  endfunction

  task automatic check_rsp(input string name, input gen_bus_rsp_t rsp, input logic [31:0] exp);
    if (rsp.busy) begin
      $display("Test %s: response taken while busy was high", name);
      test_ok = 1'b0;
    end else if (rsp.rdata !== exp) begin
      $display("[ERROR] %s: rdata expected %h, actual %h", name, exp, rsp.rdata);
      test_ok = 1'b0;
    end
  endtask

  task automatic check_grant_order(input string name, input requester_t exp,
                                   input requester_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: first port expected %s, actual %s", name, exp.name(), act.name());
      test_ok = 1'b0;
    end
  endtask

  task automatic check_cycles(input string name, input string what, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, exp, act);
      test_ok = 1'b0;
    end
  endtask

  // Samples at the falling edge, cyc counts cycles since the request
  task automatic wait_done(input string name, input string label, input logic watch_data,
                           input logic watch_instr, inout int cyc,
                           output requester_t who, output gen_bus_rsp_t rsp);
    int waited;
    waited = 0;
    who    = REQ_NONE;
    rsp    = '0;
    while (who == REQ_NONE && waited < TIMEOUT) begin
      @(negedge CLK);
      cyc++;
      waited++;
      if (!data_rsp.busy && !instr_rsp.busy) begin
        $display("Test %s: both ports reported completion together", name);
        test_ok = 1'b0;
      end
      if (watch_data && !data_rsp.busy) begin
        who = REQ_DATA;
        rsp = data_rsp;
      end else if (watch_instr && !instr_rsp.busy) begin
        who = REQ_INSTR;
        rsp = instr_rsp;
      end else if (!data_rsp.busy || !instr_rsp.busy) begin
        $display("Test %s: a port finished an access it never requested", name);
        test_ok = 1'b0;
      end
    end
    if (who == REQ_NONE) begin
      $display("Test %s: %s port never finished within %0d cycles", name, label, TIMEOUT);
      test_ok   = 1'b0;
      timed_out = 1'b1;
    end
  endtask

  // Drop the strobe, busy must be back high one cycle later
  task automatic finish_port(input string name, input requester_t who, inout int cyc);
    @(posedge CLK);
    #DRIVE_DLY;
    if (who == REQ_DATA) data_req = '0;
    else instr_req = '0;
    @(negedge CLK);
    cyc++;
    if ((who == REQ_DATA && !data_rsp.busy) || (who == REQ_INSTR && !instr_rsp.busy)) begin
      $display("Test %s: busy stayed low for more than one cycle", name);
      test_ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    if (test_ok) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic run_vector(input string name, input string port, input string op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input logic [31:0] exp, input string order);
    gen_bus_req_t req;
    requester_t   who;
    requester_t   first;
    gen_bus_rsp_t rsp;
    int           cyc;
    int           first_cyc;
    test_ok = 1'b1;
    rng     = xorshift_step(rng);
    repeat (rng[1:0]) @(posedge CLK);        // 0 to 3 idle cycles
    @(posedge CLK);
    #DRIVE_DLY;
    if (op == "W") begin                     // Golden word must follow the merge rule
      if (merge_lanes(shadow.exists(addr) ? shadow[addr] : 32'h0, wdata, be) !== exp) begin
        $display("Test %s: golden word is not the lane merge of the previous one", name);
        test_ok = 1'b0;
      end
      shadow[addr] = exp;
    end
    req         = '0;
    req.addr    = addr;
    req.wdata   = wdata;
    req.byte_en = be;
    req.ren     = (op == "R");
    req.wen     = (op == "W");
    if (port == "I") instr_req = req;
    else data_req = req;
    if (port == "B") begin                   // Fetch reads the same word
      instr_req = '0;
      instr_req.addr = addr;
      instr_req.ren  = 1'b1;
    end
    cyc = -1;
    if (port == "B") begin
      wait_done(name, "either", 1'b1, 1'b1, cyc, first, rsp);
      first_cyc = cyc;
      if (first != REQ_NONE) begin
        check_grant_order(name, order_to_req(order), first);
        check_cycles(name, "first latency", LATENCY, cyc);
        if (op == "R" || first == REQ_INSTR) check_rsp(name, rsp, exp);
        finish_port(name, first, cyc);
        wait_done(name, "second", first == REQ_INSTR, first == REQ_DATA, cyc, who, rsp);
        if (who != REQ_NONE) begin
          check_cycles(name, "completion gap", ORDER_GAP, cyc - first_cyc);
          if (op == "R" || who == REQ_INSTR) check_rsp(name, rsp, exp);
          finish_port(name, who, cyc);
        end
      end
    end else begin
      wait_done(name, port, port == "D", port == "I", cyc, who, rsp);
      if (who != REQ_NONE) begin
        check_cycles(name, "latency", LATENCY, cyc);
        if (op == "R") check_rsp(name, rsp, exp);   // Write data comes back unchecked
        finish_port(name, who, cyc);
      end
    end
    report_test(name);
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    string       port;
    string       op;
    string       order;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [3:0]  be;
    rst        = 1'b1;
    instr_req  = '0;
    data_req   = '0;
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    rng        = 32'ha33b;
    repeat (5) @(posedge CLK);
    #DRIVE_DLY rst = 1'b0;
    test_ok = 1'b1;                          // Both ports idle out of reset
    @(negedge CLK);
    if (!data_rsp.busy || !instr_rsp.busy) begin
      $display("Test reset_busy: a busy output was low after reset");
      test_ok = 1'b0;
    end
    report_test("reset_busy");
    fd = $fopen("verif/mem_golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("Golden vector file could not be opened");
      fail_count++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%s %s %s %h %h %h %h %s", name, port, op, addr, wdata, be, exp, order);
        if (n != 8) begin
          $display("Golden line could not be parsed: %s", line);
          fail_count++;
        end else begin
          run_vector(name, port, op, addr, wdata, be, exp, order);
        end
      end
      $fclose(fd);
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
